// ==== motion_config.svh ====
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// active frame size
`define H_PIXEL    800
`define V_PIXEL    600

// coordinate widths
`define X_W        11
`define Y_W        10

// luma difference above which a pixel counts as moving
`define DIFF_THR   60

// merge distance in pixels
`define MIN_DISC   100

// tracker count and object count width
`define OBJ_SLOTS  8
`define CNT_W      4

// red in RGB565
`define BORDER_RAW 16'hF800

`endif

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

    // one RGB565 word, read as fields or as a raw word
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } rgb;
    } pixel_u;

endpackage

`default_nettype wire

// ==== motion_detect.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module motion_detect import video_pkg::*; (
    input  logic            cam_pclk,
    input  logic            reset,
    input  logic            pix_valid,
    input  logic            href,
    input  logic            vsync,
    input  pixel_u          pix_in,
    input  logic [7:0]      prev_y,
    output logic            det_valid,
    output pixel_u          det_pixel,
    output logic [7:0]      det_luma,
    output logic            det_motion,
    output logic [`X_W-1:0] det_x,
    output logic [`Y_W-1:0] det_y,
    output logic            frame_start
);

    logic [7:0]      r8;
    logic [7:0]      g8;
    logic [7:0]      b8;
    logic [15:0]     luma_sum;
    logic [7:0]      luma;
    logic [7:0]      diff;
    logic [`X_W-1:0] x_cnt;
    logic [`Y_W-1:0] y_cnt;
    logic            href_d;
    logic            vsync_d;

    // widen each field by repeating its top bits
    assign r8 = {pix_in.rgb.r, pix_in.rgb.r[4:2]};
    assign g8 = {pix_in.rgb.g, pix_in.rgb.g[5:4]};
    assign b8 = {pix_in.rgb.b, pix_in.rgb.b[4:2]};

    // weights sum to 256, so the top byte is the luma
    assign luma_sum = 16'd77 * {8'd0, r8} + 16'd150 * {8'd0, g8} + 16'd29 * {8'd0, b8};
    assign luma     = luma_sum[15:8];
    assign diff     = (luma > prev_y) ? luma - prev_y : prev_y - luma;

    // pixel counter, held at the last column on overlong lines
    always_ff @(posedge cam_pclk) begin
        if (reset) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_d  <= href;
            vsync_d <= vsync;
            if (!href) begin
                x_cnt <= '0;
            end else if (pix_valid && x_cnt != `X_W'(`H_PIXEL - 1)) begin
                x_cnt <= x_cnt + 1'b1;
            end
            // line count advances on the end of each line
            if (vsync) begin
                y_cnt <= '0;
            end else if (href_d && !href && y_cnt != `Y_W'(`V_PIXEL - 1)) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge cam_pclk) begin
        if (reset) begin
            det_valid   <= 1'b0;
            det_motion  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            det_valid   <= pix_valid;
            det_motion  <= pix_valid && (diff > `DIFF_THR);
            frame_start <= vsync && !vsync_d;
        end
    end

    always_ff @(posedge cam_pclk) begin
        det_pixel <= pix_in;
        det_luma  <= luma;
        det_x     <= x_cnt;
        det_y     <= y_cnt;
    end

endmodule

`default_nettype wire

// ==== obj_slot.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module obj_slot (
    input  logic            cam_pclk,
    input  logic            reset,
    input  logic            det_valid,
    input  logic            det_motion,
    input  logic [`X_W-1:0] det_x,
    input  logic [`Y_W-1:0] det_y,
    input  logic            frame_start,
    input  logic            match_in,
    input  logic            free_in,
    input  logic            any_match,
    output logic            match_out,
    output logic            free_out,
    output logic            lat_valid,
    output logic [`X_W-1:0] lat_xmin,
    output logic [`X_W-1:0] lat_xmax,
    output logic [`Y_W-1:0] lat_ymin,
    output logic [`Y_W-1:0] lat_ymax
);

    localparam logic [`X_W-1:0] DISC_X = `MIN_DISC;
    localparam logic [`Y_W-1:0] DISC_Y = `MIN_DISC;

    logic            box_valid;
    logic [`X_W-1:0] box_xmin;
    logic [`X_W-1:0] box_xmax;
    logic [`Y_W-1:0] box_ymin;
    logic [`Y_W-1:0] box_ymax;
    logic [`X_W-1:0] win_xlo;
    logic [`X_W:0]   win_xhi;
    logic [`Y_W-1:0] win_ylo;
    logic [`Y_W:0]   win_yhi;
    logic            moving;
    logic            hit;
    logic            claim_match;
    logic            claim_free;

    assign moving = det_valid && det_motion;

    // merge window, low edge saturates at zero
    assign win_xlo = (box_xmin > DISC_X) ? box_xmin - DISC_X : '0;
    assign win_xhi = {1'b0, box_xmax} + {1'b0, DISC_X};
    assign win_ylo = (box_ymin > DISC_Y) ? box_ymin - DISC_Y : '0;
    assign win_yhi = {1'b0, box_ymax} + {1'b0, DISC_Y};

    assign hit = moving && box_valid
              && det_x >= win_xlo && {1'b0, det_x} <= win_xhi
              && det_y >= win_ylo && {1'b0, det_y} <= win_yhi;

    // priority chains, lower index wins
    assign match_out   = match_in || hit;
    assign free_out    = free_in || !box_valid;
    assign claim_match = hit && !match_in;
    assign claim_free  = moving && !any_match && !box_valid && !free_in;

    always_ff @(posedge cam_pclk) begin
        if (reset) begin
            box_valid <= 1'b0;
            lat_valid <= 1'b0;
        end else if (frame_start) begin
            lat_valid <= box_valid;
            box_valid <= 1'b0;
        end else if (claim_free) begin
            box_valid <= 1'b1;
        end
    end

    always_ff @(posedge cam_pclk) begin
        if (frame_start) begin
            lat_xmin <= box_xmin;
            lat_xmax <= box_xmax;
            lat_ymin <= box_ymin;
            lat_ymax <= box_ymax;
        end else if (claim_free) begin
            // new box starts as the single pixel
            box_xmin <= det_x;
            box_xmax <= det_x;
            box_ymin <= det_y;
            box_ymax <= det_y;
        end else if (claim_match) begin
            if (det_x < box_xmin) box_xmin <= det_x;
            if (det_x > box_xmax) box_xmax <= det_x;
            if (det_y < box_ymin) box_ymin <= det_y;
            if (det_y > box_ymax) box_ymax <= det_y;
        end
    end

endmodule

`default_nettype wire

// ==== box_overlay.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module box_overlay import video_pkg::*; (
    input  logic                               cam_pclk,
    input  logic                               reset,
    input  logic                               det_valid,
    input  pixel_u                             det_pixel,
    input  logic [7:0]                         det_luma,
    input  logic                               det_motion,
    input  logic [`X_W-1:0]                    det_x,
    input  logic [`Y_W-1:0]                    det_y,
    input  logic                               frame_start,
    input  logic [`OBJ_SLOTS-1:0]              lat_valid,
    input  logic [`OBJ_SLOTS-1:0][`X_W-1:0]    lat_xmin,
    input  logic [`OBJ_SLOTS-1:0][`X_W-1:0]    lat_xmax,
    input  logic [`OBJ_SLOTS-1:0][`Y_W-1:0]    lat_ymin,
    input  logic [`OBJ_SLOTS-1:0][`Y_W-1:0]    lat_ymax,
    output logic                               out_valid,
    output pixel_u                             out_pixel,
    output logic                               out_motion,
    output logic [7:0]                         luma_out,
    output logic [`CNT_W-1:0]                  obj_num
);

    logic              on_edge;
    logic              in_xr;
    logic              in_yr;
    logic              count_now;
    logic [`CNT_W-1:0] valid_cnt;
    pixel_u            ovl_pix;

    // border test against every latched box
    always_comb begin
        on_edge = 1'b0;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            in_xr = det_x >= lat_xmin[i] && det_x <= lat_xmax[i];
            in_yr = det_y >= lat_ymin[i] && det_y <= lat_ymax[i];
            if (lat_valid[i]) begin
                if ((det_x == lat_xmin[i] || det_x == lat_xmax[i]) && in_yr) on_edge = 1'b1;
                if ((det_y == lat_ymin[i] || det_y == lat_ymax[i]) && in_xr) on_edge = 1'b1;
            end
        end
    end

    always_comb begin
        ovl_pix = det_pixel;
        if (on_edge) ovl_pix.raw = `BORDER_RAW;
    end

    always_comb begin
        valid_cnt = '0;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            valid_cnt = valid_cnt + {{(`CNT_W - 1){1'b0}}, lat_valid[i]};
        end
    end

    always_ff @(posedge cam_pclk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_motion <= 1'b0;
            count_now  <= 1'b0;
            obj_num    <= '0;
        end else begin
            out_valid  <= det_valid;
            out_motion <= det_motion;
            // slots latch on frame_start, count one cycle later
            count_now  <= frame_start;
            if (count_now) obj_num <= valid_cnt;
        end
    end

    always_ff @(posedge cam_pclk) begin
        out_pixel <= ovl_pix;
        luma_out  <= det_luma;
    end

endmodule

`default_nettype wire

// ==== mov_check_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module mov_check_top import video_pkg::*; (
    input  logic              cam_pclk,
    input  logic              reset,
    input  logic              pix_valid,
    input  logic              href,
    input  logic              vsync,
    input  pixel_u            pix_in,
    input  logic [7:0]        prev_y,
    output logic              out_valid,
    output pixel_u            out_pixel,
    output logic              out_motion,
    output logic [7:0]        luma_out,
    output logic [`CNT_W-1:0] obj_num
);

    logic                            det_valid;
    pixel_u                          det_pixel;
    logic [7:0]                      det_luma;
    logic                            det_motion;
    logic [`X_W-1:0]                 det_x;
    logic [`Y_W-1:0]                 det_y;
    logic                            frame_start;
    logic [`OBJ_SLOTS:0]             match_chain;
    logic [`OBJ_SLOTS:0]             free_chain;
    logic [`OBJ_SLOTS-1:0]           lat_valid;
    logic [`OBJ_SLOTS-1:0][`X_W-1:0] lat_xmin;
    logic [`OBJ_SLOTS-1:0][`X_W-1:0] lat_xmax;
    logic [`OBJ_SLOTS-1:0][`Y_W-1:0] lat_ymin;
    logic [`OBJ_SLOTS-1:0][`Y_W-1:0] lat_ymax;

    // chain heads, nothing below slot 0
    assign match_chain[0] = 1'b0;
    assign free_chain[0]  = 1'b0;

    motion_detect u_motion_detect (
        .cam_pclk   (cam_pclk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .href       (href),
        .vsync      (vsync),
        .pix_in     (pix_in),
        .prev_y     (prev_y),
        .det_valid  (det_valid),
        .det_pixel  (det_pixel),
        .det_luma   (det_luma),
        .det_motion (det_motion),
        .det_x      (det_x),
        .det_y      (det_y),
        .frame_start(frame_start)
    );

    for (genvar i = 0; i < `OBJ_SLOTS; i++) begin : g_slot
        obj_slot u_obj_slot (
            .cam_pclk   (cam_pclk),
            .reset      (reset),
            .det_valid  (det_valid),
            .det_motion (det_motion),
            .det_x      (det_x),
            .det_y      (det_y),
            .frame_start(frame_start),
            .match_in   (match_chain[i]),
            .free_in    (free_chain[i]),
            .any_match  (match_chain[`OBJ_SLOTS]),
            .match_out  (match_chain[i+1]),
            .free_out   (free_chain[i+1]),
            .lat_valid  (lat_valid[i]),
            .lat_xmin   (lat_xmin[i]),
            .lat_xmax   (lat_xmax[i]),
            .lat_ymin   (lat_ymin[i]),
            .lat_ymax   (lat_ymax[i])
        );
    end

    box_overlay u_box_overlay (
        .cam_pclk   (cam_pclk),
        .reset      (reset),
        .det_valid  (det_valid),
        .det_pixel  (det_pixel),
        .det_luma   (det_luma),
        .det_motion (det_motion),
        .det_x      (det_x),
        .det_y      (det_y),
        .frame_start(frame_start),
        .lat_valid  (lat_valid),
        .lat_xmin   (lat_xmin),
        .lat_xmax   (lat_xmax),
        .lat_ymin   (lat_ymin),
        .lat_ymax   (lat_ymax),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_motion (out_motion),
        .luma_out   (luma_out),
        .obj_num    (obj_num)
    );

endmodule

`default_nettype wire

// ==== mov_check_properties.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module mov_check_properties (
    input logic              cam_pclk,
    input logic              reset,
    input logic              pix_valid,
    input logic              out_valid,
    input logic [`CNT_W-1:0] obj_num
);

    // output stage is cleared by reset
    assert property (@(posedge cam_pclk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // two register stages, never stalled
    assert property (@(posedge cam_pclk) disable iff (reset)
        out_valid == $past(pix_valid, 2))
        else $error("out_valid does not follow pix_valid by two cycles");

    assert property (@(posedge cam_pclk) obj_num <= `OBJ_SLOTS)
        else $error("obj_num above the number of slots");

endmodule

bind mov_check_top mov_check_properties u_properties (
    .cam_pclk (cam_pclk),
    .reset    (reset),
    .pix_valid(pix_valid),
    .out_valid(out_valid),
    .obj_num  (obj_num)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic cam_pclk,
    output logic reset
);

    // 8 ns pixel clock
    initial begin
        cam_pclk = 1'b0;
        forever #4 cam_pclk = ~cam_pclk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge cam_pclk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_mov_check.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "motion_config.svh"

module tb_mov_check import video_pkg::*; ();

    localparam int FRAMES   = 8;
    localparam int LINE_GAP = 6;
    localparam int VS_LEN   = 12;
    localparam int VS_BACK  = 8;
    localparam int FRAME_W[FRAMES] = '{64, 64, 200, 800, 800, 800, 800, 64};
    localparam int FRAME_H[FRAMES] = '{8, 8, 40, 160, 160, 160, 160, 8};

    logic              cam_pclk;
    logic              reset;
    logic              pix_valid;
    logic              href;
    logic              vsync;
    pixel_u            pix_in;
    logic [7:0]        prev_y;
    logic              out_valid;
    pixel_u            out_pixel;
    logic              out_motion;
    logic [7:0]        luma_out;
    logic [`CNT_W-1:0] obj_num;

    string names[FRAMES] = '{"reset_luma", "threshold", "one_blob", "two_blobs",
                             "merge", "slot_limit", "no_motion", "cleared"};
    string  test_name;
    // boxes as valid, xmin, xmax, ymin, ymax
    int     live[`OBJ_SLOTS][5];
    int     lat[`OBJ_SLOTS][5];
    int     exp_count;
    // blobs as frame, x, y, width, height
    int     blobs[32][5];
    int     n_blobs;
    pixel_u     exp_pix[$];
    logic [7:0] exp_luma[$];
    logic       exp_mot[$];
    string      exp_name[$];
    int     pix_errs;
    int     luma_errs;
    int     mot_errs;
    int     cnt_errs;
    int     other_errs;

    tb_clock_gen u_clock_gen (
        .cam_pclk(cam_pclk),
        .reset   (reset)
    );

    mov_check_top DUT (
        .cam_pclk  (cam_pclk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .href      (href),
        .vsync     (vsync),
        .pix_in    (pix_in),
        .prev_y    (prev_y),
        .out_valid (out_valid),
        .out_pixel (out_pixel),
        .out_motion(out_motion),
        .luma_out  (luma_out),
        .obj_num   (obj_num)
    );

    task automatic check_pixel(input string name, input pixel_u exp, input pixel_u act);
        if (act !== exp) begin
            pix_errs++;
            $display("ERR %s pixel expected %h actual %h (r %0d g %0d b %0d)", name,
                     exp.raw, act.raw, act.rgb.r, act.rgb.g, act.rgb.b);
        end
    endtask

    task automatic check_luma(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            luma_errs++;
            $display("ERR %s luma expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_motion(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mot_errs++;
            $display("ERR %s motion expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [`CNT_W-1:0] exp,
                               input logic [`CNT_W-1:0] act);
        if (act !== exp) begin
            cnt_errs++;
            $display("ERR %s obj_num expected %0d actual %0d", name, exp, act);
        end
    endtask

    // fields widened by repeating top bits and weighted 77/150/29 over 256
    function automatic int luma_of(input pixel_u p);
        int r8;
        int g8;
        int b8;
        r8 = (int'(p.rgb.r) << 3) | (int'(p.rgb.r) >> 2);
        g8 = (int'(p.rgb.g) << 2) | (int'(p.rgb.g) >> 4);
        b8 = (int'(p.rgb.b) << 3) | (int'(p.rgb.b) >> 2);
        return (77 * r8 + 150 * g8 + 29 * b8) >> 8;
    endfunction

    function automatic pixel_u ref_pixel(input pixel_u p, input int prev, input int x,
                                         input int y, output logic [7:0] luma,
                                         output logic motion);
        pixel_u o;
        int     d;
        o = p;
        luma = 8'(luma_of(p));
        d = luma_of(p) - prev;
        if (d < 0) d = -d;
        motion = d > `DIFF_THR;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            if (lat[i][0] != 0 &&
                (((x == lat[i][1] || x == lat[i][2]) && y >= lat[i][3] && y <= lat[i][4]) ||
                 ((y == lat[i][3] || y == lat[i][4]) && x >= lat[i][1] && x <= lat[i][2])))
                o.raw = `BORDER_RAW;
        end
        return o;
    endfunction

    // lowest matching box widens or the lowest empty slot opens or the pixel drops
    task automatic track(input int x, input int y);
        int hit;
        hit = -1;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            if (hit < 0 && live[i][0] != 0 &&
                x >= live[i][1] - `MIN_DISC && x <= live[i][2] + `MIN_DISC &&
                y >= live[i][3] - `MIN_DISC && y <= live[i][4] + `MIN_DISC)
                hit = i;
        end
        if (hit >= 0) begin
            if (x < live[hit][1]) live[hit][1] = x;
            if (x > live[hit][2]) live[hit][2] = x;
            if (y < live[hit][3]) live[hit][3] = y;
            if (y > live[hit][4]) live[hit][4] = y;
        end else begin
            for (int i = 0; i < `OBJ_SLOTS; i++) begin
                if (hit < 0 && live[i][0] == 0) hit = i;
            end
            if (hit >= 0) live[hit] = '{1, x, x, y, y};
        end
    endtask

    task automatic latch_boxes();
        exp_count = 0;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            lat[i] = live[i];
            if (live[i][0] != 0) exp_count++;
            live[i][0] = 0;
        end
    endtask

    task automatic add_blob(input int f, input int x, input int y, input int w, input int h);
        blobs[n_blobs] = '{f, x, y, w, h};
        n_blobs++;
    endtask

    function automatic bit blob_at(input int f, input int x, input int y);
        for (int i = 0; i < n_blobs; i++) begin
            if (blobs[i][0] == f && x >= blobs[i][1] && x < blobs[i][1] + blobs[i][3] &&
                y >= blobs[i][2] && y < blobs[i][2] + blobs[i][4])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic run_frame(input int f);
        pixel_u     p;
        pixel_u     ep;
        logic [7:0] el;
        logic       em;
        int         x;
        int         li;
        int         d;
        int         pv;
        test_name = names[f];
        @(posedge cam_pclk);
        vsync <= 1'b1;
        latch_boxes();
        repeat (VS_LEN) @(posedge cam_pclk);
        vsync <= 1'b0;
        repeat (VS_BACK) @(posedge cam_pclk);
        @(negedge cam_pclk);
        check_count(test_name, `CNT_W'(exp_count), obj_num);
        for (int y = 0; y < FRAME_H[f]; y++) begin
            x = 0;
            while (x < FRAME_W[f]) begin
                @(posedge cam_pclk);
                href <= 1'b1;
                if ($urandom % 16 == 0) begin
                    pix_valid <= 1'b0;
                end else begin
                    p.raw = 16'($urandom);
                    li = luma_of(p);
                    // frame 1 sits right on the threshold on both sides
                    if (blob_at(f, x, y))
                        d = `DIFF_THR + 1 + ((f == 1) ? 0 : int'($urandom % 30));
                    else
                        d = (f == 1) ? `DIFF_THR : 0;
                    pv = (li >= d && ($urandom % 2 == 0 || li + d > 255)) ? li - d : li + d;
                    pix_valid <= 1'b1;
                    pix_in    <= p;
                    prev_y    <= 8'(pv);
                    ep = ref_pixel(p, pv, x, y, el, em);
                    exp_pix.push_back(ep);
                    exp_luma.push_back(el);
                    exp_mot.push_back(em);
                    exp_name.push_back(test_name);
                    if (em) track(x, y);
                    x++;
                end
            end
            @(posedge cam_pclk);
            href      <= 1'b0;
            pix_valid <= 1'b0;
            repeat (LINE_GAP - 1) @(posedge cam_pclk);
        end
    endtask

    always @(negedge cam_pclk) begin
        if (!reset && out_valid) begin
            if (exp_pix.size() == 0) begin
                other_errs++;
                $display("an output pixel appeared with no input pixel left to match it");
            end else begin
                check_pixel(exp_name[0], exp_pix[0], out_pixel);
                check_luma(exp_name[0], exp_luma[0], luma_out);
                check_motion(exp_name[0], exp_mot[0], out_motion);
                exp_pix.delete(0);
                exp_luma.delete(0);
                exp_mot.delete(0);
                exp_name.delete(0);
            end
        end
    end

    initial begin
        int total;
        pix_valid = 1'b0;
        href      = 1'b0;
        vsync     = 1'b0;
        pix_in    = '0;
        prev_y    = 8'd0;
        void'($urandom(99));
        add_blob(1, 10, 2, 6, 3);
        add_blob(2, 50, 10, 20, 8);
        add_blob(3, 100, 20, 10, 10);
        add_blob(3, 400, 60, 10, 10);
        // second blob sits inside the merge distance of the first
        add_blob(4, 100, 20, 10, 10);
        add_blob(4, 160, 50, 10, 10);
        for (int k = 0; k < 6; k++) begin
            add_blob(5, 20 + 150 * k, 10, 4, 4);
        end
        for (int k = 0; k < 3; k++) begin
            add_blob(5, 20 + 150 * k, 140, 4, 4);
        end
        @(negedge reset);
        @(negedge cam_pclk);
        if (out_valid !== 1'b0) begin
            other_errs++;
            $display("out_valid is not low after reset");
        end
        check_motion("after_reset", 1'b0, out_motion);
        check_count("after_reset", '0, obj_num);
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        while (exp_pix.size() != 0) @(negedge cam_pclk);
        repeat (4) @(negedge cam_pclk);
        total = pix_errs + luma_errs + mot_errs + cnt_errs + other_errs;
        $display("errors: pixel %0d, luma %0d, motion %0d, count %0d, other %0d",
                 pix_errs, luma_errs, mot_errs, cnt_errs, other_errs);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // frame lengths with idle cycles plus a tenth
    initial begin
        longint cycles;
        cycles = 60;
        for (int f = 0; f < FRAMES; f++) begin
            cycles += VS_LEN + VS_BACK + 2
                    + FRAME_H[f] * (FRAME_W[f] + FRAME_W[f] / 8 + LINE_GAP);
        end
        #(cycles * 8 * 11 / 10);
        $display("timeout: the frames did not complete in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
video_pkg.sv
motion_detect.sv
obj_slot.sv
box_overlay.sv
mov_check_top.sv
mov_check_properties.sv
tb_clock_gen.sv
tb_mov_check.sv

// ==== run.sh ====
#!/bin/sh
# build and run the motion detector testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_mov_check -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
